// File: sources.f
hdl/fetch_pkg.sv
hdl/bram_1r1w.sv
hdl/icache_direct.sv
hdl/fetch_uncached.sv
hdl/fetch_select.sv
hdl/fetch_top.sv
sim/bus_memory.sv
sim/tb_fetch.sv

// File: run.sh
#!/bin/sh
# Build the fetch path testbench with Verilator and run it.
# The run counts as passing only if the pass line shows up in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch \
	-f sources.f -o tb_fetch &&
./obj_dir/tb_fetch | tee /dev/stderr | grep -qF '*** PASSED ***' ||
exit 1

// File: sim/tb_fetch.sv
// Testbench for the instruction fetch path with a bus memory, a reference model and assertions.
`timescale 1ns/10ps
`default_nettype none

module tb_fetch;

	localparam int          TIMEOUT = 200;
	localparam logic [31:0] CODE_KEY = 32'hC0DE_0000;
	localparam logic [31:0] FIRST_PC = 32'h0000_0080;
	localparam logic [31:0] STREAM_BASE = 32'h0000_1000;
	localparam logic [31:0] CONFLICT_A = 32'h0000_2040;
	localparam logic [31:0] CONFLICT_B = 32'h0000_3040;
	localparam logic [31:0] IO_A = 32'h8000_0100;
	localparam logic [31:0] IO_B = 32'h8000_0200;

	logic        clock;
	logic        reset;
	logic [31:0] pc;
	logic [31:0] instr;
	logic        ready;
	logic        bus_request;
	logic [31:0] bus_address;
	logic        bus_ready;
	logic [31:0] bus_rdata;
	logic [31:0] hit_count;
	logic [31:0] miss_count;

	// Reference model of the cache lines and the uncached word.
	logic [fetch_pkg::TAG_BITS-1:0] model_tag [fetch_pkg::SETS];
	logic                           model_valid [fetch_pkg::SETS];
	logic [31:0]                    model_held;
	logic                           model_held_valid;
	int unsigned                    model_hits;
	int unsigned                    model_misses;

	int unsigned bus_done;
	int          errors;
	int          tests;
	int          failed_tests;
	bit          aborted;
	integer      seed;

	fetch_top dut (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_pc          (pc),
		.o_instr       (instr),
		.o_ready       (ready),
		.o_bus_request (bus_request),
		.o_bus_address (bus_address),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_hit_count   (hit_count),
		.o_miss_count  (miss_count)
	);

	bus_memory memory (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_bus_request (bus_request),
		.i_bus_address (bus_address),
		.o_bus_ready   (bus_ready),
		.o_bus_rdata   (bus_rdata)
	);

	always #20 clock = ~clock;

	// Completed bus transactions.
	always @(posedge clock) begin
		if (!reset && bus_request && bus_ready) begin
			bus_done <= bus_done + 1;
		end
	end

	// A ready word must be the memory word at the program counter.
	instr_matches_pc: assert property (@(posedge clock) disable iff (reset)
		ready |-> instr == (pc ^ CODE_KEY))
	else begin
		errors++;
		$display("Error o_instr: got %h, expected %h", $sampled(instr),
			$sampled(pc) ^ CODE_KEY);
	end

	request_held: assert property (@(posedge clock) disable iff (reset)
		bus_request && !bus_ready |=> bus_request && $stable(bus_address))
	else begin
		errors++;
		$display("Bus request dropped or its address moved before ready");
	end

	request_released: assert property (@(posedge clock) disable iff (reset)
		bus_request && bus_ready |=> !bus_request)
	else begin
		errors++;
		$display("Bus request still high on the cycle after ready");
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual == expected)
		else begin
			errors++;
			$display("Error %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic check_counters();
		check_value("o_hit_count", hit_count, model_hits);
		check_value("o_miss_count", miss_count, model_misses);
	endtask

	// Drive one program counter and wait for its word.
	task automatic fetch(input logic [31:0] addr, output int wait_cycles);
		logic [fetch_pkg::SET_BITS-1:0] line_set;
		logic [fetch_pkg::TAG_BITS-1:0] line_tag;
		logic                           cached;
		logic                           expect_bus;
		int unsigned                    start_done;
		wait_cycles = 0;
		if (!aborted) begin
			cached = !addr[fetch_pkg::UNCACHED_BIT];
			line_set = addr[fetch_pkg::SET_BITS+1:2];
			line_tag = addr[31 -: fetch_pkg::TAG_BITS];
			if (cached) begin
				expect_bus = !(model_valid[line_set] && model_tag[line_set] == line_tag);
			end else begin
				expect_bus = !(model_held_valid && model_held == addr);
			end
			start_done = bus_done;
			@(posedge clock);
			pc <= addr;
			@(negedge clock);
			// Counters cover every earlier fetch by now.
			check_counters();
			while (!ready && wait_cycles < TIMEOUT) begin
				@(negedge clock);
				wait_cycles++;
			end
			if (!ready) begin
				errors++;
				aborted = 1'b1;
				$display("o_ready did not rise within %0d cycles for pc %h", TIMEOUT, addr);
			end else begin
				check_value("o_instr", instr, addr ^ CODE_KEY);
				check_value("bus_done", bus_done - start_done, {31'd0, expect_bus});
				if (cached) begin
					if (expect_bus) begin
						model_misses++;
						model_valid[line_set] = 1'b1;
						model_tag[line_set] = line_tag;
					end
					model_hits++;
				end else begin
					model_held = addr;
					model_held_valid = 1'b1;
				end
			end
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		@(negedge clock);
		if (!aborted) begin
			check_counters();
		end
		tests++;
		if (errors == start_errors) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("Test %0d %s: %0d errors", tests, name, errors - start_errors);
		end
	endtask

	initial begin
		int          cycles;
		int          start_errors;
		int unsigned start_done;
		logic [31:0] start_hits;
		logic [31:0] start_misses;
		logic [31:0] addr;
		logic [31:0] r;
		clock = 1'b0;
		reset = 1'b1;
		pc = FIRST_PC;
		bus_done = 0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		aborted = 1'b0;
		seed = 32'h57ae_fd0c;
		model_held = '0;
		model_held_valid = 1'b0;
		model_hits = 0;
		model_misses = 0;
		for (int i = 0; i < fetch_pkg::SETS; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i] = '0;
		end
		repeat (10) @(posedge clock);
		reset <= 1'b0;

		// Lines are being cleared, nothing may be served or requested.
		start_errors = errors;
		repeat (fetch_pkg::SETS) begin
			@(negedge clock);
			assert (!ready && !bus_request)
			else begin
				errors++;
				$display("o_ready or o_bus_request rose while the cache was clearing");
			end
		end
		check_counters();
		finish_test("clear after reset", start_errors);

		// The reset program counter misses on its own once clearing ends.
		start_errors = errors;
		fetch(FIRST_PC, cycles);
		fetch(32'h0000_00C4, cycles);
		fetch(FIRST_PC, cycles);
		finish_test("miss then hit", start_errors);

		start_errors = errors;
		for (int i = 0; i < 16; i++) begin
			fetch(STREAM_BASE + i * 4, cycles);
		end
		for (int i = 0; i < 16; i++) begin
			fetch(STREAM_BASE + i * 4, cycles);
			// First word of the walk needs one read.
			if (i > 0 && !aborted) begin
				assert (cycles == 0)
				else begin
					errors++;
					$display("Streamed fetch at %h waited %0d cycles", STREAM_BASE + i * 4,
						cycles);
				end
			end
		end
		finish_test("sequential streaming", start_errors);

		start_errors = errors;
		start_misses = model_misses;
		for (int i = 0; i < 4; i++) begin
			fetch(CONFLICT_A, cycles);
			fetch(CONFLICT_B, cycles);
		end
		check_value("o_miss_count", miss_count, start_misses + 8);
		finish_test("conflict eviction", start_errors);

		start_errors = errors;
		start_hits = model_hits;
		start_misses = model_misses;
		start_done = bus_done;
		fetch(IO_A, cycles);
		fetch(IO_B, cycles);
		fetch(IO_A, cycles);
		fetch(IO_B, cycles);
		check_value("bus_done", bus_done - start_done, 32'd4);
		@(negedge clock);
		check_value("o_hit_count", hit_count, start_hits);
		check_value("o_miss_count", miss_count, start_misses);
		finish_test("uncached region", start_errors);

		// Cached fetches span sets 0 to 7 with two tags.
		start_errors = errors;
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			if (i % 2 == 0) begin
				addr = 32'h0000_4000 | {21'd0, r[3], 5'd0, r[2:0], 2'b00};
			end else begin
				addr = 32'h8000_2000 | {28'd0, r[5:4], 2'b00};
			end
			fetch(addr, cycles);
		end
		finish_test("region switch", start_errors);

		$display("Tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/bus_memory.sv
// Behavioral instruction memory that answers each bus request after a random delay.
`timescale 1ns/10ps
`default_nettype none

module bus_memory (
	input  wire         i_clock,
	input  wire         i_reset,
	input  wire         i_bus_request,
	input  wire  [31:0] i_bus_address,
	output logic        o_bus_ready,
	output logic [31:0] o_bus_rdata
);

	integer seed = 32'h57ae_fd0c;
	logic   busy;
	int     delay;

	// One ready pulse per request, 0 to 5 extra cycles after it is seen.
	always @(posedge i_clock) begin
		o_bus_ready <= 1'b0;
		if (i_reset) begin
			busy <= 1'b0;
			delay <= 0;
			o_bus_rdata <= '0;
		end else if (busy) begin
			if (delay == 0) begin
				o_bus_ready <= 1'b1;
				o_bus_rdata <= i_bus_address ^ 32'hC0DE_0000;
				busy <= 1'b0;
			end else begin
				delay <= delay - 1;
			end
		end else if (i_bus_request && !o_bus_ready) begin
			// Request is still high on the cycle of the pulse.
			busy <= 1'b1;
			delay <= $unsigned($random(seed)) % 6;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
// Instruction fetch top level joining the cache, the uncached path and the bus selector.
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
	input  wire         i_clock,
	input  wire         i_reset,

	// Processor side.
	input  wire  [31:0] i_pc,
	output logic [31:0] o_instr,
	output logic        o_ready,

	// Instruction bus.
	output logic        o_bus_request,
	output logic [31:0] o_bus_address,
	input  wire         i_bus_ready,
	input  wire  [31:0] i_bus_rdata,

	// Cache counters.
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);

	logic        cache_enable;
	logic        cache_ready;
	logic [31:0] cache_rdata;
	logic        cache_request;
	logic [31:0] cache_address;
	logic        cache_bus_ready;
	logic        uncached_enable;
	logic        uncached_ready;
	logic [31:0] uncached_rdata;
	logic        uncached_request;
	logic [31:0] uncached_address;
	logic        uncached_bus_ready;

	icache_direct cache (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (cache_enable),
		.i_pc          (i_pc),
		.o_ready       (cache_ready),
		.o_rdata       (cache_rdata),
		.o_bus_request (cache_request),
		.o_bus_address (cache_address),
		.i_bus_ready   (cache_bus_ready),
		.i_bus_rdata   (i_bus_rdata),
		.o_hit_count   (o_hit_count),
		.o_miss_count  (o_miss_count)
	);

	fetch_uncached uncached (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (uncached_enable),
		.i_pc          (i_pc),
		.o_ready       (uncached_ready),
		.o_rdata       (uncached_rdata),
		.o_bus_request (uncached_request),
		.o_bus_address (uncached_address),
		.i_bus_ready   (uncached_bus_ready),
		.i_bus_rdata   (i_bus_rdata)
	);

	fetch_select select (
		.i_clock              (i_clock),
		.i_reset              (i_reset),
		.i_pc                 (i_pc),
		.o_cache_enable       (cache_enable),
		.o_uncached_enable    (uncached_enable),
		.i_cache_ready        (cache_ready),
		.i_cache_rdata        (cache_rdata),
		.i_cache_request      (cache_request),
		.i_cache_address      (cache_address),
		.i_uncached_ready     (uncached_ready),
		.i_uncached_rdata     (uncached_rdata),
		.i_uncached_request   (uncached_request),
		.i_uncached_address   (uncached_address),
		.o_cache_bus_ready    (cache_bus_ready),
		.o_uncached_bus_ready (uncached_bus_ready),
		.o_ready              (o_ready),
		.o_instr              (o_instr),
		.o_bus_request        (o_bus_request),
		.o_bus_address        (o_bus_address),
		.i_bus_ready          (i_bus_ready)
	);

endmodule

`default_nettype wire

// File: hdl/fetch_select.sv
// Region decoder and bus arbiter that combines the cached and uncached fetch paths.
`timescale 1ns/10ps
`default_nettype none

module fetch_select (
	input  wire         i_clock,
	input  wire         i_reset,
	input  wire  [31:0] i_pc,

	// Path enables.
	output logic        o_cache_enable,
	output logic        o_uncached_enable,

	// Cached path.
	input  wire         i_cache_ready,
	input  wire  [31:0] i_cache_rdata,
	input  wire         i_cache_request,
	input  wire  [31:0] i_cache_address,

	// Uncached path.
	input  wire         i_uncached_ready,
	input  wire  [31:0] i_uncached_rdata,
	input  wire         i_uncached_request,
	input  wire  [31:0] i_uncached_address,

	// Ready pulses routed back to the owning path.
	output logic        o_cache_bus_ready,
	output logic        o_uncached_bus_ready,

	// Processor and bus.
	output logic        o_ready,
	output logic [31:0] o_instr,
	output logic        o_bus_request,
	output logic [31:0] o_bus_address,
	input  wire         i_bus_ready
);

	fetch_pkg::bus_owner_t owner;
	logic                  uncached;

	assign uncached = i_pc[fetch_pkg::UNCACHED_BIT];

	assign o_cache_enable = !uncached;
	assign o_uncached_enable = uncached;

	assign o_ready = uncached ? i_uncached_ready : i_cache_ready;
	assign o_instr = uncached ? i_uncached_rdata : i_cache_rdata;

	// Bus follows the owner.
	always_comb begin
		if (owner == fetch_pkg::OWNER_UNCACHED) begin
			o_bus_request = i_uncached_request;
			o_bus_address = i_uncached_address;
		end else begin
			o_bus_request = i_cache_request;
			o_bus_address = i_cache_address;
		end
	end

	assign o_cache_bus_ready = i_bus_ready && (owner == fetch_pkg::OWNER_CACHE);
	assign o_uncached_bus_ready = i_bus_ready && (owner == fetch_pkg::OWNER_UNCACHED);

	// Hand the bus over only between requests, to a path that is waiting.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			owner <= fetch_pkg::OWNER_CACHE;
		end else if (!o_bus_request) begin
			if (owner == fetch_pkg::OWNER_CACHE && i_uncached_request) begin
				owner <= fetch_pkg::OWNER_UNCACHED;
			end else if (owner == fetch_pkg::OWNER_UNCACHED && i_cache_request) begin
				owner <= fetch_pkg::OWNER_CACHE;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_uncached.sv
// Uncached fetch path that keeps only the last word read from the bus.
`timescale 1ns/10ps
`default_nettype none

module fetch_uncached (
	input  wire         i_clock,
	input  wire         i_reset,
	input  wire         i_enable,
	input  wire  [31:0] i_pc,
	output logic        o_ready,
	output logic [31:0] o_rdata,

	// Instruction bus.
	output logic        o_bus_request,
	output logic [31:0] o_bus_address,
	input  wire         i_bus_ready,
	input  wire  [31:0] i_bus_rdata
);

	logic        valid;
	logic [31:0] held_address;
	logic        stale;

	// Held word no longer belongs to the program counter.
	assign stale = !valid || (held_address != i_pc);

	assign o_ready = !stale;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid <= 1'b0;
			o_bus_request <= 1'b0;
		end else if (o_bus_request) begin
			if (i_bus_ready) begin
				valid <= 1'b1;
				o_bus_request <= 1'b0;
			end
		end else if (i_enable && stale) begin
			valid <= 1'b0;
			o_bus_request <= 1'b1;
		end
	end

	// Address and word payload.
	always_ff @(posedge i_clock) begin
		if (!o_bus_request && i_enable && stale) begin
			o_bus_address <= i_pc;
		end
		if (o_bus_request && i_bus_ready) begin
			held_address <= o_bus_address;
			o_rdata <= i_bus_rdata;
		end
	end

endmodule

`default_nettype wire

// File: hdl/icache_direct.sv
// Direct-mapped instruction cache with bus refill, clear after reset and event counters.
`timescale 1ns/10ps
`default_nettype none

module icache_direct (
	input  wire         i_clock,
	input  wire         i_reset,
	input  wire         i_enable,
	input  wire  [31:0] i_pc,
	output logic        o_ready,
	output logic [31:0] o_rdata,

	// Instruction bus.
	output logic        o_bus_request,
	output logic [31:0] o_bus_address,
	input  wire         i_bus_ready,
	input  wire  [31:0] i_bus_rdata,

	// Event counters.
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);

	fetch_pkg::cache_state_t state;

	logic [fetch_pkg::SET_BITS-1:0]  pc_set;
	logic [fetch_pkg::TAG_BITS-1:0]  pc_tag;
	logic [fetch_pkg::SET_BITS-1:0]  clear_set;
	logic [fetch_pkg::SET_BITS-1:0]  rd_set;
	logic [fetch_pkg::SET_BITS-1:0]  set_r;
	logic [fetch_pkg::LINE_BITS-1:0] rd_line;
	logic                            wr_request;
	logic [fetch_pkg::SET_BITS-1:0]  wr_set;
	logic [fetch_pkg::LINE_BITS-1:0] wr_line;
	logic [fetch_pkg::SET_BITS-1:0]  refill_set;
	logic [fetch_pkg::TAG_BITS-1:0]  refill_tag;
	logic [31:0]                     refill_data;
	logic                            line_stale;
	logic                            line_match;
	logic                            lookup_hit;
	logic                            lookup_miss;
	logic                            hold_valid;
	logic                            hold_hit;
	logic [31:0]                     hold_pc;
	logic [31:0]                     hold_data;
	logic                            ready_r;
	logic [31:0]                     pc_r;

	assign pc_set = i_pc[fetch_pkg::SET_BITS+1:2];
	assign pc_tag = i_pc[31 -: fetch_pkg::TAG_BITS];

	bram_1r1w lines (
		.i_clock      (i_clock),
		.i_rd_address (rd_set),
		.o_rd_data    (rd_line),
		.i_wr_request (wr_request),
		.i_wr_address (wr_set),
		.i_wr_data    (wr_line)
	);

	// Registered line belongs to set_r, and is only trusted one read after a write.
	assign line_match = rd_line[fetch_pkg::LINE_BITS-1] &&
		(rd_line[fetch_pkg::LINE_BITS-2 -: fetch_pkg::TAG_BITS] == pc_tag);
	assign lookup_hit = (state == fetch_pkg::CACHE_LOOKUP) && i_enable && !line_stale &&
		(set_r == pc_set) && line_match;

	// Last hit word covers the cycles where the read port moved on to the next set.
	assign hold_hit = i_enable && hold_valid && (hold_pc == i_pc);
	assign lookup_miss = (state == fetch_pkg::CACHE_LOOKUP) && i_enable && !line_stale &&
		(set_r == pc_set) && !line_match && !hold_hit;

	assign o_ready = lookup_hit || hold_hit;
	assign o_rdata = lookup_hit ? rd_line[31:0] : hold_data;

	// Prefetch the next set on a hit so sequential code streams.
	assign rd_set = lookup_hit ? pc_set + 1'b1 : pc_set;

	// Write port clears lines, then stores refilled lines.
	assign wr_request = (state == fetch_pkg::CACHE_CLEAR) || (state == fetch_pkg::CACHE_WRITE);
	assign wr_set = (state == fetch_pkg::CACHE_CLEAR) ? clear_set : refill_set;
	assign wr_line = (state == fetch_pkg::CACHE_CLEAR) ? '0 : {1'b1, refill_tag, refill_data};

	always_ff @(posedge i_clock) begin
		set_r <= rd_set;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::CACHE_CLEAR;
			clear_set <= '0;
			o_bus_request <= 1'b0;
			line_stale <= 1'b1;
			o_miss_count <= '0;
		end else begin
			line_stale <= wr_request;
			case (state)
				fetch_pkg::CACHE_CLEAR: begin
					clear_set <= clear_set + 1'b1;
					// Last set written when the counter is all ones.
					if (&clear_set) begin
						state <= fetch_pkg::CACHE_LOOKUP;
					end
				end
				fetch_pkg::CACHE_LOOKUP: begin
					if (lookup_miss) begin
						o_bus_request <= 1'b1;
						o_miss_count <= o_miss_count + 1'b1;
						state <= fetch_pkg::CACHE_REFILL;
					end
				end
				fetch_pkg::CACHE_REFILL: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= fetch_pkg::CACHE_WRITE;
					end
				end
				default: begin
					state <= fetch_pkg::CACHE_LOOKUP;
				end
			endcase
		end
	end

	// Refill payload.
	always_ff @(posedge i_clock) begin
		if (state == fetch_pkg::CACHE_LOOKUP && lookup_miss) begin
			refill_set <= pc_set;
			refill_tag <= pc_tag;
			o_bus_address <= i_pc;
		end
		if (state == fetch_pkg::CACHE_REFILL && i_bus_ready) begin
			refill_data <= i_bus_rdata;
		end
	end

	// Hold register and hit counting, one hit per fetch served.
	always_ff @(posedge i_clock) begin
		pc_r <= i_pc;
		if (lookup_hit) begin
			hold_pc <= i_pc;
			hold_data <= rd_line[31:0];
		end
		if (i_reset) begin
			hold_valid <= 1'b0;
			ready_r <= 1'b0;
			o_hit_count <= '0;
		end else begin
			ready_r <= o_ready;
			if (lookup_hit) begin
				hold_valid <= 1'b1;
			end
			if (o_ready && !(ready_r && pc_r == i_pc)) begin
				o_hit_count <= o_hit_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/bram_1r1w.sv
// Block RAM for cache lines with one registered read port and one write port.
`timescale 1ns/10ps
`default_nettype none

module bram_1r1w (
	input  wire                             i_clock,

	// Read port.
	input  wire  [fetch_pkg::SET_BITS-1:0]  i_rd_address,
	output logic [fetch_pkg::LINE_BITS-1:0] o_rd_data,

	// Write port.
	input  wire                             i_wr_request,
	input  wire  [fetch_pkg::SET_BITS-1:0]  i_wr_address,
	input  wire  [fetch_pkg::LINE_BITS-1:0] i_wr_data
);

	logic [fetch_pkg::LINE_BITS-1:0] mem [fetch_pkg::SETS];

	// Read every cycle.
	// A write to the same address shows up one cycle later.
	always_ff @(posedge i_clock) begin
		o_rd_data <= mem[i_rd_address];
	end

	always_ff @(posedge i_clock) begin
		if (i_wr_request) begin
			mem[i_wr_address] <= i_wr_data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
// Fetch path package with cache geometry, the region rule and state encodings.
`default_nettype none

package fetch_pkg;

	// Direct-mapped cache geometry, one word per line.
	localparam int SET_BITS = 6;
	localparam int SETS = 1 << SET_BITS;

	// Word address is 30 bits, the rest above the set index is tag.
	localparam int TAG_BITS = 30 - SET_BITS;

	// Stored line is valid bit, tag and one data word.
	localparam int LINE_BITS = 1 + TAG_BITS + 32;

	// Addresses with this bit set bypass the cache.
	localparam int UNCACHED_BIT = 31;

	// Cache sequencer states.
	typedef enum logic [1:0] {
		CACHE_CLEAR,
		CACHE_LOOKUP,
		CACHE_REFILL,
		CACHE_WRITE
	} cache_state_t;

	// Which fetch path currently drives the instruction bus.
	typedef enum logic {
		OWNER_CACHE,
		OWNER_UNCACHED
	} bus_owner_t;

endpackage

`default_nettype wire
